//--- src/slot_pkg.sv
package slot_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and sizes

  localparam int DATA_W        = 128;
  localparam int STRB_W        = DATA_W / 8;
  localparam int MEM_WORDS     = 256;
  localparam int MEM_ADDR_W    = $clog2(MEM_WORDS);
  localparam int DMA_ADDR_W    = 16;
  localparam int WORD_LSB      = $clog2(STRB_W);
  localparam int REG_LENGTH    = 1;
  localparam int PORT_W        = 3;
  localparam int ROUTE_ENTRIES = 1 << PORT_W;

  // Longer packets leave as two descriptors
  localparam logic [15:0] SPLIT_LEN = 16'd1024;

  ////////////////////////////////////////////////////////////
  // Descriptor views

  typedef enum logic [1:0] {
    PKT  = 2'd0,
    CTRL = 2'd1
  } desc_type_e;

  typedef struct packed {
    desc_type_e        dtype;
    logic [PORT_W-1:0] port;
    logic [10:0]       pad;
    logic [15:0]       len;
    logic [31:0]       addr;
  } pkt_desc_t;

  typedef struct packed {
    desc_type_e  dtype;
    logic [1:0]  status_addr;
    logic [27:0] pad;
    logic [31:0] value;
  } ctrl_desc_t;

  // Same top two bits in both views
  typedef union packed {
    pkt_desc_t  pkt;
    ctrl_desc_t ctrl;
  } desc_u;

  typedef struct packed {
    logic  desc_2nd;
    desc_u desc;
  } out_desc_t;

  ////////////////////////////////////////////////////////////
  // DMA and status channels

  typedef struct packed {
    logic [DMA_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     data;
    logic [STRB_W-1:0]     strb;
    logic                  last;
  } dma_wr_t;

  typedef struct packed {
    logic [DMA_ADDR_W-1:0] addr;
    logic                  last;
  } dma_rd_t;

  typedef struct packed {
    logic [PORT_W-1:0] addr;
    logic [31:0]       data;
  } status_wr_t;

  typedef struct packed {
    logic [1:0]  addr;
    logic [31:0] data;
  } core_status_t;

endpackage

//--- src/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  T     s_data,
  input  logic s_valid,
  output logic s_ready,
  output T     m_data,
  output logic m_valid,
  input  logic m_ready
);

  // Link i feeds stage i, stage i drives link i+1
  T     link_data  [DEPTH+1];
  logic link_valid [DEPTH+1];
  logic link_ready [DEPTH+1];

  assign link_data[0]      = s_data;
  assign link_valid[0]     = s_valid;
  assign s_ready           = link_ready[0];
  assign m_data            = link_data[DEPTH];
  assign m_valid           = link_valid[DEPTH];
  assign link_ready[DEPTH] = m_ready;

  for (genvar i = 0; i < DEPTH; i++) begin : g_stage
    T     main_q;
    T     skid_q;
    logic valid_q;
    logic ready_q;
    logic drain;

    // Main entry free or leaving this cycle
    assign drain = !valid_q || link_ready[i+1];

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q <= 1'b0;
        ready_q <= 1'b1;
      end else if (ready_q) begin
        if (drain) begin
          valid_q <= link_valid[i];
        end else if (link_valid[i]) begin
          // Item parked in skid, close input
          ready_q <= 1'b0;
        end
      end else if (link_ready[i+1]) begin
        ready_q <= 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (ready_q) begin
        skid_q <= link_data[i];
        if (drain) begin
          main_q <= link_data[i];
        end
      end else if (link_ready[i+1]) begin
        main_q <= skid_q;
      end
    end

    assign link_data[i+1]  = main_q;
    assign link_valid[i+1] = valid_q;
    assign link_ready[i]   = ready_q;
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

//--- src/packet_mem.sv
`timescale 1ns/1ps

module packet_mem (
  input  logic                         clk,
  input  logic                         rst_n,
  input  slot_pkg::dma_wr_t            wr,
  input  logic                         wr_valid,
  output logic                         wr_ready,
  input  slot_pkg::dma_rd_t            rd,
  input  logic                         rd_valid,
  output logic                         rd_ready,
  output logic [slot_pkg::DATA_W-1:0]  resp_data,
  output logic                         resp_valid,
  input  logic                         resp_ready
);

  import slot_pkg::*;

  logic [DATA_W-1:0]     mem [MEM_WORDS];
  logic [MEM_ADDR_W-1:0] wr_word;
  logic [MEM_ADDR_W-1:0] rd_word;
  logic                  wr_fire;
  logic                  rd_fire;

  // Byte offset bits dropped
  assign wr_word = wr.addr[WORD_LSB +: MEM_ADDR_W];
  assign rd_word = rd.addr[WORD_LSB +: MEM_ADDR_W];

  assign wr_ready = 1'b1;
  assign wr_fire  = wr_valid && wr_ready;

  // Open when response slot is empty or being taken
  assign rd_ready = !resp_valid || resp_ready;
  assign rd_fire  = rd_valid && rd_ready;

  ////////////////////////////////////////////////////////////
  // Strobed write port

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr.strb[b]) begin
          mem[wr_word][8*b +: 8] <= wr.data[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port with held response

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (rd_fire) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      resp_data <= mem[rd_word];
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |-> !rd_fire ##1 resp_valid && $stable(resp_data));

  // Upper address bits must stay inside the array
  assert property (@(posedge clk) disable iff (!rst_n)
    wr_fire |-> wr.addr[DMA_ADDR_W-1:WORD_LSB] < MEM_WORDS);

endmodule

//--- src/desc_engine.sv
`timescale 1ns/1ps

module desc_engine (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   core_reset,
  input  slot_pkg::desc_u        in_desc,
  input  logic                   in_valid,
  output logic                   in_ready,
  output slot_pkg::out_desc_t    out_desc,
  output logic                   out_valid,
  input  logic                   out_ready,
  input  slot_pkg::status_wr_t   status_wr,
  input  logic                   status_wr_valid,
  output slot_pkg::core_status_t core_status
);

  import slot_pkg::*;

  logic              eng_rst_n;
  logic [PORT_W-1:0] route [ROUTE_ENTRIES];
  logic              split_pend;
  logic              advance;
  logic              accept;
  logic              is_pkt;
  logic              is_ctrl;
  logic              is_long;
  pkt_desc_t         head;
  pkt_desc_t         tail;
  pkt_desc_t         tail_q;

  assign eng_rst_n = rst_n && !core_reset;

  ////////////////////////////////////////////////////////////
  // Decode and split

  assign is_pkt  = in_desc.pkt.dtype == PKT;
  assign is_ctrl = in_desc.ctrl.dtype == CTRL;
  assign is_long = in_desc.pkt.len > SPLIT_LEN;

  always_comb begin
    head      = in_desc.pkt;
    head.port = route[in_desc.pkt.port];
    tail      = head;
    if (is_long) begin
      head.len  = SPLIT_LEN;
      tail.len  = in_desc.pkt.len - SPLIT_LEN;
      tail.addr = in_desc.pkt.addr + 32'(SPLIT_LEN);
    end
  end

  // Output register free next edge; second half blocks input
  assign advance  = !out_valid || out_ready;
  assign in_ready = advance && !split_pend;
  assign accept   = in_valid && in_ready;

  ////////////////////////////////////////////////////////////
  // Control state

  always_ff @(posedge clk) begin
    if (!eng_rst_n) begin
      out_valid   <= 1'b0;
      split_pend  <= 1'b0;
      core_status <= '0;
      for (int p = 0; p < ROUTE_ENTRIES; p++) begin
        route[p] <= PORT_W'(p);
      end
    end else begin
      if (status_wr_valid) begin
        route[status_wr.addr] <= status_wr.data[PORT_W-1:0];
      end
      if (advance) begin
        out_valid  <= split_pend || (accept && is_pkt);
        split_pend <= accept && is_pkt && is_long;
      end
      if (accept && is_ctrl) begin
        core_status.addr <= in_desc.ctrl.status_addr;
        core_status.data <= in_desc.ctrl.value;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Descriptor payload

  always_ff @(posedge clk) begin
    if (advance) begin
      if (split_pend) begin
        out_desc.desc.pkt <= tail_q;
        out_desc.desc_2nd <= 1'b1;
      end else begin
        out_desc.desc.pkt <= head;
        out_desc.desc_2nd <= 1'b0;
      end
    end
    if (accept) begin
      tail_q <= tail;
    end
  end

  // First half of a split leaves without the flag
  assert property (@(posedge clk) disable iff (!eng_rst_n)
    out_valid && split_pend |-> !out_desc.desc_2nd);

  // Second half continues where the first one ends
  assert property (@(posedge clk) disable iff (!eng_rst_n)
    out_valid && out_ready && split_pend |=>
      out_valid && out_desc.desc_2nd &&
      out_desc.desc.pkt.addr == $past(out_desc.desc.pkt.addr) + 32'(SPLIT_LEN));

endmodule

//--- src/core_slot.sv
`timescale 1ns/1ps

module core_slot (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        core_reset,
  input  slot_pkg::dma_wr_t           dma_wr,
  input  logic                        dma_wr_valid,
  output logic                        dma_wr_ready,
  input  slot_pkg::dma_rd_t           dma_rd,
  input  logic                        dma_rd_valid,
  output logic                        dma_rd_ready,
  output logic [slot_pkg::DATA_W-1:0] rd_resp_data,
  output logic                        rd_resp_valid,
  input  logic                        rd_resp_ready,
  input  slot_pkg::desc_u             in_desc,
  input  logic                        in_desc_valid,
  output logic                        in_desc_ready,
  output slot_pkg::out_desc_t         out_desc,
  output logic                        out_desc_valid,
  input  logic                        out_desc_ready,
  input  slot_pkg::status_wr_t        status_wr,
  input  logic                        status_wr_valid,
  output slot_pkg::core_status_t      core_status
);

  import slot_pkg::*;

  ////////////////////////////////////////////////////////////
  // Registered resets and status

  logic         rst_n_r;
  logic         core_reset_r;
  logic         desc_rst_n;
  status_wr_t   status_wr_r;
  logic         status_wr_valid_r;
  core_status_t core_status_n;

  always_ff @(posedge clk) begin
    rst_n_r      <= rst_n;
    core_reset_r <= core_reset;
  end

  // Descriptor side also cleared by core reset
  assign desc_rst_n = rst_n_r && !core_reset_r;

  always_ff @(posedge clk) begin
    if (!rst_n_r) begin
      status_wr_valid_r <= 1'b0;
      core_status       <= '0;
    end else begin
      status_wr_valid_r <= status_wr_valid;
      core_status       <= core_status_n;
    end
  end

  always_ff @(posedge clk) begin
    status_wr_r <= status_wr;
  end

  ////////////////////////////////////////////////////////////
  // DMA crossings

  dma_wr_t           dma_wr_r;
  logic              dma_wr_valid_r;
  logic              dma_wr_ready_r;
  dma_rd_t           dma_rd_r;
  logic              dma_rd_valid_r;
  logic              dma_rd_ready_r;
  logic [DATA_W-1:0] resp_data_n;
  logic              resp_valid_n;
  logic              resp_ready_n;

  pipe_reg #(.T(dma_wr_t), .DEPTH(REG_LENGTH)) u_dma_wr_pipe (
    .clk     (clk),
    .rst_n   (rst_n_r),
    .s_data  (dma_wr),
    .s_valid (dma_wr_valid),
    .s_ready (dma_wr_ready),
    .m_data  (dma_wr_r),
    .m_valid (dma_wr_valid_r),
    .m_ready (dma_wr_ready_r)
  );

  pipe_reg #(.T(dma_rd_t), .DEPTH(REG_LENGTH)) u_dma_rd_pipe (
    .clk     (clk),
    .rst_n   (rst_n_r),
    .s_data  (dma_rd),
    .s_valid (dma_rd_valid),
    .s_ready (dma_rd_ready),
    .m_data  (dma_rd_r),
    .m_valid (dma_rd_valid_r),
    .m_ready (dma_rd_ready_r)
  );

  pipe_reg #(.T(logic [DATA_W-1:0]), .DEPTH(REG_LENGTH)) u_rd_resp_pipe (
    .clk     (clk),
    .rst_n   (rst_n_r),
    .s_data  (resp_data_n),
    .s_valid (resp_valid_n),
    .s_ready (resp_ready_n),
    .m_data  (rd_resp_data),
    .m_valid (rd_resp_valid),
    .m_ready (rd_resp_ready)
  );

  packet_mem u_packet_mem (
    .clk        (clk),
    .rst_n      (rst_n_r),
    .wr         (dma_wr_r),
    .wr_valid   (dma_wr_valid_r),
    .wr_ready   (dma_wr_ready_r),
    .rd         (dma_rd_r),
    .rd_valid   (dma_rd_valid_r),
    .rd_ready   (dma_rd_ready_r),
    .resp_data  (resp_data_n),
    .resp_valid (resp_valid_n),
    .resp_ready (resp_ready_n)
  );

  ////////////////////////////////////////////////////////////
  // Descriptor crossings

  desc_u     in_desc_r;
  logic      in_desc_valid_r;
  logic      in_desc_ready_r;
  out_desc_t out_desc_n;
  logic      out_desc_valid_n;
  logic      out_desc_ready_n;

  pipe_reg #(.T(desc_u), .DEPTH(REG_LENGTH)) u_in_desc_pipe (
    .clk     (clk),
    .rst_n   (desc_rst_n),
    .s_data  (in_desc),
    .s_valid (in_desc_valid),
    .s_ready (in_desc_ready),
    .m_data  (in_desc_r),
    .m_valid (in_desc_valid_r),
    .m_ready (in_desc_ready_r)
  );

  desc_engine u_desc_engine (
    .clk             (clk),
    .rst_n           (rst_n_r),
    .core_reset      (core_reset_r),
    .in_desc         (in_desc_r),
    .in_valid        (in_desc_valid_r),
    .in_ready        (in_desc_ready_r),
    .out_desc        (out_desc_n),
    .out_valid       (out_desc_valid_n),
    .out_ready       (out_desc_ready_n),
    .status_wr       (status_wr_r),
    .status_wr_valid (status_wr_valid_r),
    .core_status     (core_status_n)
  );

  pipe_reg #(.T(out_desc_t), .DEPTH(REG_LENGTH)) u_out_desc_pipe (
    .clk     (clk),
    .rst_n   (desc_rst_n),
    .s_data  (out_desc_n),
    .s_valid (out_desc_valid_n),
    .s_ready (out_desc_ready_n),
    .m_data  (out_desc),
    .m_valid (out_desc_valid),
    .m_ready (out_desc_ready)
  );

endmodule

//--- sim/core_slot_tb.sv
`timescale 1ns/1ps

module core_slot_tb;

  import slot_pkg::*;

  logic              clk;
  logic              rst_n;
  logic              core_reset;
  dma_wr_t           dma_wr;
  logic              dma_wr_valid;
  logic              dma_wr_ready;
  dma_rd_t           dma_rd;
  logic              dma_rd_valid;
  logic              dma_rd_ready;
  logic [DATA_W-1:0] rd_resp_data;
  logic              rd_resp_valid;
  logic              rd_resp_ready;
  desc_u             in_desc;
  logic              in_desc_valid;
  logic              in_desc_ready;
  out_desc_t         out_desc;
  logic              out_desc_valid;
  logic              out_desc_ready;
  status_wr_t        status_wr;
  logic              status_wr_valid;
  core_status_t      core_status;

  out_desc_t         exp_desc [$];
  logic [DATA_W-1:0] exp_resp [$];
  string             tests [$];
  int                mismatches;
  int                failures;
  int                desc_total;
  int                desc_seen;
  int                cycles;
  int                cycle_limit;
  logic              resp_held;
  logic [DATA_W-1:0] resp_last;

  core_slot uut (.*);

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_desc(input out_desc_t got, input out_desc_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: out_desc %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_resp(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: read data %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_status(input core_status_t got, input core_status_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: core_status %h, expected %h", $time, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Output side under random back-pressure

  always @(negedge clk) begin
    if (rst_n) begin
      out_desc_ready = ($urandom & 3) != 0;
      rd_resp_ready  = ($urandom & 3) != 0;
    end
    // Stalled response must hold
    if (resp_held && !rd_resp_valid) begin
      failures++;
      $display("Read response dropped while stalled at %0t", $time);
    end else if (resp_held) begin
      check_resp(rd_resp_data, resp_last);
    end
    resp_held = rd_resp_valid && !rd_resp_ready;
    resp_last = rd_resp_data;
    if (rd_resp_valid && rd_resp_ready) begin
      if (exp_resp.size() == 0) begin
        failures++;
        $display("Read response at %0t with no read outstanding", $time);
      end else begin
        check_resp(rd_resp_data, exp_resp.pop_front());
      end
    end
    if (out_desc_valid && out_desc_ready) begin
      desc_seen++;
      if (exp_desc.size() == 0) begin
        failures++;
        $display("Unexpected descriptor %h at %0t", out_desc, $time);
      end else begin
        check_desc(out_desc, exp_desc.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, %0d descriptors still expected",
               cycle_limit, exp_desc.size());
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Input side tasks start and end on a falling edge

  task automatic dma_write(input logic [15:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb);
    dma_wr.addr  = addr;
    dma_wr.data  = data;
    dma_wr.strb  = strb;
    dma_wr.last  = 1'b1;
    dma_wr_valid = 1'b1;
    while (!dma_wr_ready) @(negedge clk);
    @(negedge clk);
    dma_wr_valid = 1'b0;
  endtask

  task automatic dma_read(input logic [15:0] addr, input logic [DATA_W-1:0] exp);
    exp_resp.push_back(exp);
    dma_rd.addr  = addr;
    dma_rd.last  = 1'b1;
    dma_rd_valid = 1'b1;
    while (!dma_rd_ready) @(negedge clk);
    @(negedge clk);
    dma_rd_valid = 1'b0;
    while (exp_resp.size() != 0) @(negedge clk);
  endtask

  task automatic send_desc(input desc_u d);
    in_desc       = d;
    in_desc_valid = 1'b1;
    while (!in_desc_ready) @(negedge clk);
    @(negedge clk);
    in_desc_valid = 1'b0;
  endtask

  task automatic drain_desc();
    while (exp_desc.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  // Expected halves follow the split rule
  task automatic run_pkt(input logic [2:0] port, input logic [15:0] len,
                         input logic [31:0] addr, input logic [2:0] exp_port);
    desc_u     d;
    out_desc_t e;
    d               = '0;
    d.pkt.dtype     = PKT;
    d.pkt.port      = port;
    d.pkt.len       = len;
    d.pkt.addr      = addr;
    e               = '0;
    e.desc          = d;
    e.desc.pkt.port = exp_port;
    if (len > SPLIT_LEN) begin
      e.desc.pkt.len = SPLIT_LEN;
      exp_desc.push_back(e);
      desc_total++;
      e.desc_2nd      = 1'b1;
      e.desc.pkt.len  = len - SPLIT_LEN;
      e.desc.pkt.addr = addr + 32'd1024;
    end
    exp_desc.push_back(e);
    desc_total++;
    send_desc(d);
  endtask

  task automatic run_ctrl(input logic [1:0] status_addr, input logic [31:0] value);
    desc_u        d;
    core_status_t e;
    int           n;
    d                  = '0;
    d.ctrl.dtype       = CTRL;
    d.ctrl.status_addr = status_addr;
    d.ctrl.value       = value;
    e.addr             = status_addr;
    e.data             = value;
    send_desc(d);
    n = 0;
    while (core_status !== e && n < 64) begin
      @(negedge clk);
      n++;
    end
    check_status(core_status, e);
  endtask

  task automatic write_route(input logic [2:0] entry, input logic [31:0] data);
    drain_desc();
    status_wr.addr  = entry;
    status_wr.data  = data;
    status_wr_valid = 1'b1;
    @(negedge clk);
    status_wr_valid = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic pulse_core_reset();
    desc_u d;
    d           = '0;
    d.pkt.dtype = PKT;
    d.pkt.len   = 16'h0040;
    d.pkt.addr  = 32'h0000_a000;
    drain_desc();
    // Still in flight when core reset lands, so it never leaves
    send_desc(d);
    core_reset = 1'b1;
    repeat (2) @(negedge clk);
    core_reset = 1'b0;
    repeat (4) @(negedge clk);
    if (out_desc_valid || !in_desc_ready) begin
      failures++;
      $display("Descriptor path not idle after core reset at %0t", $time);
    end
    check_status(core_status, '0);
  endtask

  task automatic run_line(input string line);
    byte               op;
    logic [DATA_W-1:0] a0;
    logic [DATA_W-1:0] a1;
    logic [DATA_W-1:0] a2;
    logic [DATA_W-1:0] a3;
    op = line.getc(0);
    void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a0, a1, a2, a3));
    case (op)
      "W": dma_write(a0[15:0], a1, a2[STRB_W-1:0]);
      "R": dma_read(a0[15:0], a1);
      "D": run_pkt(a0[2:0], a1[15:0], a2[31:0], a3[2:0]);
      "S": write_route(a0[2:0], a1[31:0]);
      "C": run_ctrl(a0[1:0], a1[31:0]);
      "X": pulse_core_reset();
      default: begin
        failures++;
        $display("Unknown opcode in test line: %s", line);
      end
    endcase
  endtask

  task automatic load_tests(output bit ok);
    int    fd;
    string line;
    fd = $fopen("sim/core_slot_tests.txt", "r");
    ok = fd != 0;
    if (ok) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.getc(0) >= "A" && line.getc(0) <= "Z") begin
          tests.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    bit ok;
    clk             = 1'b0;
    rst_n           = 1'b0;
    core_reset      = 1'b0;
    dma_wr          = '0;
    dma_wr_valid    = 1'b0;
    dma_rd          = '0;
    dma_rd_valid    = 1'b0;
    rd_resp_ready   = 1'b1;
    in_desc         = '0;
    in_desc_valid   = 1'b0;
    out_desc_ready  = 1'b1;
    status_wr       = '0;
    status_wr_valid = 1'b0;
    mismatches      = 0;
    failures        = 0;
    desc_total      = 0;
    desc_seen       = 0;
    cycles          = 0;
    cycle_limit     = 0;
    resp_held       = 1'b0;
    void'($urandom(32'hb4fa));
    load_tests(ok);
    if (!ok) begin
      $display("Cannot open sim/core_slot_tests.txt");
      $display("** FAIL **");
      $finish;
    end else begin
      cycle_limit = 40 * tests.size() + 100;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      repeat (2) @(negedge clk);
      if (!dma_wr_ready || !dma_rd_ready || !in_desc_ready || rd_resp_valid ||
          out_desc_valid) begin
        failures++;
        $display("Handshake signals not idle after reset");
      end
      check_status(core_status, '0);
      foreach (tests[i]) begin
        run_line(tests[i]);
      end
      drain_desc();
      if (desc_seen != desc_total) begin
        failures++;
        $display("Received %0d descriptors, expected %0d", desc_seen, desc_total);
      end
      $display("Run done: %0d mismatches, %0d other errors", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule

//--- sim/core_slot_tests.txt
# W addr data strb | R addr expected_data | D port len addr expected_port
# S route_entry port | C status_addr value | X core reset, no operands
W 0000 00112233445566778899aabbccddeeff ffff
W 0010 ffeeddccbbaa99887766554433221100 ffff
W 0ff0 0123456789abcdef0123456789abcdef ffff
W 0000 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 00ff
W 0010 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 8001
R 0000 0011223344556677a5a5a5a5a5a5a5a5
R 0018 5aeeddccbbaa9988776655443322115a
R 0ff0 0123456789abcdef0123456789abcdef
D 0 0040 00001000 0
D 5 0400 00002000 5
D 3 0401 00003000 3
D 7 0010 00003800 7
C 2 deadbeef
S 3 00000006
S 0 00000007
D 3 0100 00004000 6
D 0 1000 00005000 7
D 1 0020 00006000 1
D 3 0600 00006800 6
C 1 12345678
X
D 3 0080 00007000 3
D 0 0800 00008000 0
D 6 0002 00009000 6
R 0010 5aeeddccbbaa9988776655443322115a
C 3 cafef00d

//--- core_slot.f
src/slot_pkg.sv
src/pipe_reg.sv
src/packet_mem.sv
src/desc_engine.sv
src/core_slot.sv
sim/core_slot_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := core_slot_tb
RTL_TOP    := core_slot
FILELIST   := core_slot.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the testbench prints its pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
